// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_mem_subsystem
FILELIST = project.f
BUILD    = obj_dir
LOG      = run.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== project.f ====
src/soc_mem_pkg.sv
src/iomem_bus_ctrl.sv
src/byte_lane_ram.sv
src/uart_prog_loader.sv
src/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

// ==== src/byte_lane_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram (
  input  wire                                 clk_i,
  input  wire  [3:0]                          strb_i,
  input  wire  [soc_mem_pkg::RAM_ADDR_W-1:0]  addr_i,
  input  wire  [31:0]                         wdata_i,
  input  wire                                 rd_en_i,
  output logic [31:0]                         rdata_o
);

  // One 32-bit word per address
  logic [31:0] mem [soc_mem_pkg::RAM_WORDS];

  ////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////
  // One enable per byte lane
  always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (strb_i[lane]) begin
        mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////
  // Registered read keeps the old word on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== src/iomem_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module iomem_bus_ctrl (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  input  wire                                 cpu_rst_n_i,
  input  wire                                 iomem_valid_i,
  input  wire  [3:0]                          iomem_wstrb_i,
  input  wire  [31:0]                         iomem_addr_i,
  input  wire  [31:0]                         iomem_wdata_i,
  output logic                                iomem_ready_o,
  output logic [31:0]                         iomem_rdata_o,
  output logic [3:0]                          ram_strb_o,
  output logic [soc_mem_pkg::RAM_ADDR_W-1:0]  ram_addr_o,
  output logic [31:0]                         ram_wdata_o,
  output logic                                ram_rd_en_o,
  input  wire  [31:0]                         ram_rdata_i
);

  soc_mem_pkg::bus_region_e          region;
  logic                              ram_hit;
  logic                              ram_req_q;
  logic [soc_mem_pkg::RAM_DELAY-1:0] ram_shift_q;
  logic [63:0]                       timer_q;

  ////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////
  always_comb begin
    region = soc_mem_pkg::REG_NONE;
    if (iomem_valid_i) begin
      if ((iomem_addr_i & ~soc_mem_pkg::RAM_MASK_ADDR) == soc_mem_pkg::RAM_BASE_ADDR) begin
        region = soc_mem_pkg::REG_RAM;
      end else if (iomem_addr_i == soc_mem_pkg::TIMER_LO_ADDR) begin
        region = soc_mem_pkg::REG_TIMER_LO;
      end else if (iomem_addr_i == soc_mem_pkg::TIMER_HI_ADDR) begin
        region = soc_mem_pkg::REG_TIMER_HI;
      end
    end
  end

  assign ram_hit = (region == soc_mem_pkg::REG_RAM);

  // RAM port, strobe only for RAM window hits
  assign ram_strb_o  = ram_hit ? iomem_wstrb_i : 4'b0000;
  assign ram_rd_en_o = ram_hit & ~(|iomem_wstrb_i);
  // Word address, window aliases on RAM depth
  assign ram_addr_o  = iomem_addr_i[soc_mem_pkg::RAM_ADDR_W+1:2];
  assign ram_wdata_o = iomem_wdata_i;

  ////////////////////////////////////////////////////
  // RAM latency
  ////////////////////////////////////////////////////
  // Pending RAM request, high from cycle 1 until ready
  always_ff @(posedge clk_i) begin
    if (!cpu_rst_n_i) begin
      ram_req_q <= 1'b0;
    end else begin
      ram_req_q <= ram_hit & ~iomem_ready_o;
    end
  end

  // Request bit walks to the top in cycle RAM_DELAY+1
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ram_shift_q <= '0;
    end else if (ram_hit && iomem_ready_o) begin
      // Transfer accepted, start over for next request
      ram_shift_q <= '0;
    end else begin
      ram_shift_q <= {ram_shift_q[soc_mem_pkg::RAM_DELAY-2:0], ram_req_q};
    end
  end

  ////////////////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!cpu_rst_n_i) begin
      timer_q <= 64'd0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  // Timer and unmapped answer at once, RAM after the delay line
  assign iomem_ready_o = ram_shift_q[soc_mem_pkg::RAM_DELAY-1] |
                         (iomem_valid_i & ~ram_hit);

  // Read data select
  always_comb begin
    case (region)
      soc_mem_pkg::REG_RAM:      iomem_rdata_o = ram_rdata_i;
      soc_mem_pkg::REG_TIMER_LO: iomem_rdata_o = timer_q[31:0];
      soc_mem_pkg::REG_TIMER_HI: iomem_rdata_o = timer_q[63:32];
      default:                   iomem_rdata_o = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
  input  wire         clk_i,
  input  wire         rst_n,
  input  wire         iomem_valid_i,
  output logic        iomem_ready_o,
  input  wire  [3:0]  iomem_wstrb_i,
  input  wire  [31:0] iomem_addr_i,
  input  wire  [31:0] iomem_wdata_i,
  output logic [31:0] iomem_rdata_o,
  input  wire         prog_rx_i,
  output logic        prog_mode_o,
  output logic        cpu_rst_n_o
);

  logic                                sys_rst_n;

  // Bus side RAM port
  logic [3:0]                          bus_strb;
  logic [soc_mem_pkg::RAM_ADDR_W-1:0]  bus_addr;
  logic [31:0]                         bus_wdata;
  logic                                bus_rd_en;

  // Loader side RAM port
  logic [3:0]                          ld_strb;
  logic [soc_mem_pkg::RAM_ADDR_W-1:0]  ld_addr;
  logic [31:0]                         ld_wdata;

  // Shared RAM port
  logic [3:0]                          ram_strb;
  logic [soc_mem_pkg::RAM_ADDR_W-1:0]  ram_addr;
  logic [31:0]                         ram_wdata;
  logic                                ram_rd_en;
  logic [31:0]                         ram_rdata;

  // Board reset or loader hold
  assign cpu_rst_n_o = rst_n & sys_rst_n;

  ////////////////////////////////////////////////////
  // RAM port owner, loader wins while programming
  ////////////////////////////////////////////////////
  assign ram_strb  = prog_mode_o ? ld_strb  : bus_strb;
  assign ram_addr  = prog_mode_o ? ld_addr  : bus_addr;
  assign ram_wdata = prog_mode_o ? ld_wdata : bus_wdata;
  assign ram_rd_en = ~prog_mode_o & bus_rd_en;

  iomem_bus_ctrl u_bus_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n),
    .cpu_rst_n_i   (cpu_rst_n_o),
    .iomem_valid_i (iomem_valid_i),
    .iomem_wstrb_i (iomem_wstrb_i),
    .iomem_addr_i  (iomem_addr_i),
    .iomem_wdata_i (iomem_wdata_i),
    .iomem_ready_o (iomem_ready_o),
    .iomem_rdata_o (iomem_rdata_o),
    .ram_strb_o    (bus_strb),
    .ram_addr_o    (bus_addr),
    .ram_wdata_o   (bus_wdata),
    .ram_rd_en_o   (bus_rd_en),
    .ram_rdata_i   (ram_rdata)
  );

  byte_lane_ram u_ram (
    .clk_i   (clk_i),
    .strb_i  (ram_strb),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rd_en_i (ram_rd_en),
    .rdata_o (ram_rdata)
  );

  uart_prog_loader u_loader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n),
    .prog_rx_i   (prog_rx_i),
    .mem_strb_o  (ld_strb),
    .mem_addr_o  (ld_addr),
    .mem_wdata_o (ld_wdata),
    .prog_mode_o (prog_mode_o),
    .sys_rst_n_o (sys_rst_n)
  );

endmodule

`default_nettype wire

// ==== src/soc_mem_pkg.sv ====
`default_nettype none

package soc_mem_pkg;

  ////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////
  localparam logic [31:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK_ADDR = 32'h000F_FFFF;
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  // Simulation depth, window aliases above it
  localparam int RAM_WORDS  = 1024;
  localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

  // Cycles between RAM request and ready
  localparam int RAM_DELAY = 16;

  ////////////////////////////////////////////////////
  // Program loader UART
  ////////////////////////////////////////////////////
  localparam int CLKS_PER_BIT = 8;
  localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);
  // Last count of a full bit and of half a bit
  localparam logic [UART_CNT_W-1:0] BIT_LAST  = UART_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [UART_CNT_W-1:0] HALF_LAST = UART_CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [7:0] {PROG_CMD_LOAD = 8'hA5} prog_cmd_e;

  typedef enum logic [1:0] {LD_IDLE, LD_LEN_LO, LD_LEN_HI, LD_DATA} loader_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_BITS, RX_STOP} rx_state_e;

  // Decoded target of a bus request
  typedef enum logic [1:0] {REG_NONE, REG_RAM, REG_TIMER_LO, REG_TIMER_HI} bus_region_e;

endpackage

`default_nettype wire

// ==== src/uart_prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_prog_loader (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  input  wire                                 prog_rx_i,
  output logic [3:0]                          mem_strb_o,
  output logic [soc_mem_pkg::RAM_ADDR_W-1:0]  mem_addr_o,
  output logic [31:0]                         mem_wdata_o,
  output logic                                prog_mode_o,
  output logic                                sys_rst_n_o
);

  logic                                rx_meta_q;
  logic                                rx_sync_q;
  soc_mem_pkg::rx_state_e              rx_state_q;
  logic [soc_mem_pkg::UART_CNT_W-1:0]  bit_cnt_q;
  logic [2:0]                          bit_idx_q;
  logic [7:0]                          rx_shift_q;
  logic                                rx_valid_q;

  soc_mem_pkg::loader_state_e          ld_state_q;
  logic [15:0]                         len_q;
  logic [15:0]                         word_cnt_q;
  logic [1:0]                          byte_idx_q;
  logic [31:0]                         word_q;
  logic                                wr_q;
  logic                                prog_mode_q;

  ////////////////////////////////////////////////////
  // Serial receiver, 8N1
  ////////////////////////////////////////////////////
  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= prog_rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_state_q <= soc_mem_pkg::RX_IDLE;
      bit_cnt_q  <= '0;
      bit_idx_q  <= 3'd0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;
      bit_cnt_q  <= bit_cnt_q + 1'b1;
      case (rx_state_q)
        soc_mem_pkg::RX_IDLE: begin
          bit_cnt_q <= '0;
          if (!rx_sync_q) rx_state_q <= soc_mem_pkg::RX_START;
        end
        soc_mem_pkg::RX_START: begin
          // Middle of start bit, reject glitches
          if (bit_cnt_q == soc_mem_pkg::HALF_LAST) begin
            bit_cnt_q  <= '0;
            bit_idx_q  <= 3'd0;
            rx_state_q <= rx_sync_q ? soc_mem_pkg::RX_IDLE : soc_mem_pkg::RX_BITS;
          end
        end
        soc_mem_pkg::RX_BITS: begin
          if (bit_cnt_q == soc_mem_pkg::BIT_LAST) begin
            bit_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) rx_state_q <= soc_mem_pkg::RX_STOP;
          end
        end
        default: begin
          // Mid stop bit, byte only kept on a good frame
          if (bit_cnt_q == soc_mem_pkg::BIT_LAST) begin
            rx_valid_q <= rx_sync_q;
            rx_state_q <= soc_mem_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits, LSB first
  always_ff @(posedge clk_i) begin
    if (rx_state_q == soc_mem_pkg::RX_BITS && bit_cnt_q == soc_mem_pkg::BIT_LAST) begin
      rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
    end
  end

  ////////////////////////////////////////////////////
  // Command parser and RAM writer
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ld_state_q  <= soc_mem_pkg::LD_IDLE;
      prog_mode_q <= 1'b0;
      wr_q        <= 1'b0;
      byte_idx_q  <= 2'd0;
      word_cnt_q  <= 16'd0;
    end else begin
      case (ld_state_q)
        soc_mem_pkg::LD_IDLE: begin
          // Anything but the load command is dropped
          if (rx_valid_q && rx_shift_q == soc_mem_pkg::PROG_CMD_LOAD) begin
            ld_state_q  <= soc_mem_pkg::LD_LEN_LO;
            prog_mode_q <= 1'b1;
          end
        end
        soc_mem_pkg::LD_LEN_LO: begin
          if (rx_valid_q) ld_state_q <= soc_mem_pkg::LD_LEN_HI;
        end
        soc_mem_pkg::LD_LEN_HI: begin
          if (rx_valid_q) begin
            byte_idx_q <= 2'd0;
            word_cnt_q <= 16'd0;
            // Empty image, done right away
            if ({rx_shift_q, len_q[7:0]} == 16'd0) begin
              ld_state_q  <= soc_mem_pkg::LD_IDLE;
              prog_mode_q <= 1'b0;
            end else begin
              ld_state_q <= soc_mem_pkg::LD_DATA;
            end
          end
        end
        default: begin
          if (wr_q) begin
            // Word written this cycle
            wr_q       <= 1'b0;
            word_cnt_q <= word_cnt_q + 16'd1;
            if (word_cnt_q == len_q - 16'd1) begin
              ld_state_q  <= soc_mem_pkg::LD_IDLE;
              prog_mode_q <= 1'b0;
            end
          end else if (rx_valid_q) begin
            byte_idx_q <= byte_idx_q + 2'd1;
            if (byte_idx_q == 2'd3) wr_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // Length and word payload
  always_ff @(posedge clk_i) begin
    if (rx_valid_q) begin
      if (ld_state_q == soc_mem_pkg::LD_LEN_LO) len_q[7:0] <= rx_shift_q;
      if (ld_state_q == soc_mem_pkg::LD_LEN_HI) len_q[15:8] <= rx_shift_q;
      // Little endian, first byte ends up in bits 7:0
      if (ld_state_q == soc_mem_pkg::LD_DATA) word_q <= {rx_shift_q, word_q[31:8]};
    end
  end

  assign mem_strb_o  = {4{wr_q}};
  assign mem_addr_o  = word_cnt_q[soc_mem_pkg::RAM_ADDR_W-1:0];
  assign mem_wdata_o = word_q;
  assign prog_mode_o = prog_mode_q;
  // Processor held while the image loads
  assign sys_rst_n_o = ~prog_mode_q;

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

  logic        clk_i = 1'b0;
  logic        rst_n;
  logic        iomem_valid_i;
  logic [3:0]  iomem_wstrb_i;
  logic [31:0] iomem_addr_i;
  logic [31:0] iomem_wdata_i;
  logic        prog_rx_i;
  wire         iomem_ready_o;
  wire  [31:0] iomem_rdata_o;
  wire         prog_mode_o;
  wire         cpu_rst_n_o;

  // Shadow copy of the RAM words
  logic [31:0] shadow [soc_mem_pkg::RAM_WORDS];
  logic [63:0] timer_model = '1;
  int unsigned cyc_cnt = 0;
  int unsigned accept_cyc = 0;
  integer      seed = 32;
  logic [7:0]  image [12];

  mem_subsystem_top UUT (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .iomem_valid_i (iomem_valid_i),
    .iomem_ready_o (iomem_ready_o),
    .iomem_wstrb_i (iomem_wstrb_i),
    .iomem_addr_i  (iomem_addr_i),
    .iomem_wdata_i (iomem_wdata_i),
    .iomem_rdata_o (iomem_rdata_o),
    .prog_rx_i     (prog_rx_i),
    .prog_mode_o   (prog_mode_o),
    .cpu_rst_n_o   (cpu_rst_n_o)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      abort_run($sformatf("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got));
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic soc_mem_pkg::bus_region_e region_of(input logic [31:0] addr);
    if ((addr & ~soc_mem_pkg::RAM_MASK_ADDR) == soc_mem_pkg::RAM_BASE_ADDR) begin
      return soc_mem_pkg::REG_RAM;
    end
    if (addr == soc_mem_pkg::TIMER_LO_ADDR) return soc_mem_pkg::REG_TIMER_LO;
    if (addr == soc_mem_pkg::TIMER_HI_ADDR) return soc_mem_pkg::REG_TIMER_HI;
    return soc_mem_pkg::REG_NONE;
  endfunction

  // Window aliases every RAM_WORDS words
  function automatic int unsigned word_of(input logic [31:0] addr);
    return (addr >> 2) % soc_mem_pkg::RAM_WORDS;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[i*8 +: 8] = wdata[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [31:0] addr, input logic [63:0] timer);
    case (region_of(addr))
      soc_mem_pkg::REG_RAM:      return shadow[word_of(addr)];
      soc_mem_pkg::REG_TIMER_LO: return timer[31:0];
      soc_mem_pkg::REG_TIMER_HI: return timer[63:32];
      default:                   return 32'd0;
    endcase
  endfunction

  // Mid-cycle sampling, inputs and outputs settled
  always @(negedge clk_i) begin
    // All ones, so first cycle out of reset reads zero
    if (!cpu_rst_n_o) timer_model = '1;
    else timer_model = timer_model + 64'd1;
    cyc_cnt = cyc_cnt + 1;
    if (iomem_valid_i && iomem_ready_o) begin
      accept_cyc = cyc_cnt;
      if (iomem_wstrb_i == 4'b0000) begin
        check_equal("iomem_rdata_o", expected_rdata(iomem_addr_i, timer_model), iomem_rdata_o);
      end else if (region_of(iomem_addr_i) == soc_mem_pkg::REG_RAM) begin
        shadow[word_of(iomem_addr_i)] = merge_bytes(shadow[word_of(iomem_addr_i)],
                                                    iomem_wdata_i, iomem_wstrb_i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////
  // Entered and left 1 ns after a rising edge
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    int exp_wait;
    waited = 0;
    exp_wait = (region_of(addr) == soc_mem_pkg::REG_RAM) ? soc_mem_pkg::RAM_DELAY + 1 : 0;
    iomem_valid_i = 1'b1;
    iomem_addr_i  = addr;
    iomem_wstrb_i = strb;
    iomem_wdata_i = wdata;
    @(negedge clk_i);
    while (!iomem_ready_o) begin
      if (waited > 100) abort_run($sformatf("No ready for request to address %h", addr));
      waited++;
      @(negedge clk_i);
    end
    rdata = iomem_rdata_o;
    check_equal("ready latency", exp_wait, waited);
    @(posedge clk_i);
    #1;
    iomem_valid_i = 1'b0;
  endtask

  // 8N1 frame, then two idle bit times
  task automatic uart_send(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      prog_rx_i = frame[i];
      repeat (soc_mem_pkg::CLKS_PER_BIT) @(posedge clk_i);
      #1;
    end
    repeat (2 * soc_mem_pkg::CLKS_PER_BIT) @(posedge clk_i);
    #1;
  endtask

  // Fill value mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'hA5A5_5A5A;
  endfunction

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rd_val;
    logic [31:0] val_a;
    logic [31:0] addr;
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [31:0] pick;
    int unsigned cyc_a;
    int          waited;
    rst_n         = 1'b0;
    iomem_valid_i = 1'b0;
    iomem_wstrb_i = 4'b0000;
    iomem_addr_i  = 32'd0;
    iomem_wdata_i = 32'd0;
    prog_rx_i     = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk_i);
    check_equal("iomem_ready_o", 32'd0, 32'(iomem_ready_o));
    check_equal("prog_mode_o", 32'd0, 32'(prog_mode_o));
    check_equal("cpu_rst_n_o", 32'd1, 32'(cpu_rst_n_o));
    @(posedge clk_i);
    #1;

    // Full-word fill, then partial strobes, some through aliases
    for (int i = 0; i < 32; i++) begin
      addr = soc_mem_pkg::RAM_BASE_ADDR + 32'(i * 4);
      bus_access(addr, 4'b1111, fill_word(addr), rd_val);
    end
    bus_access(32'h4000_000C, 4'b0001, 32'h1122_3344, rd_val);
    bus_access(32'h4000_0010, 4'b0110, 32'h5566_7788, rd_val);
    bus_access(32'h4001_0014, 4'b1000, 32'h99AA_BBCC, rd_val);
    for (int i = 0; i < 8; i++) begin
      bus_access(soc_mem_pkg::RAM_BASE_ADDR + 32'(i * 4), 4'b0000, 32'd0, rd_val);
    end
    bus_access(32'h4008_0000, 4'b0000, 32'd0, rd_val);

    // Timer deltas follow accept edges
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, 4'b0000, 32'd0, val_a);
    cyc_a = accept_cyc;
    repeat (5) @(posedge clk_i);
    #1;
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, 4'b0000, 32'd0, rd_val);
    check_equal("timer_lo delta", accept_cyc - cyc_a, rd_val - val_a);
    bus_access(soc_mem_pkg::TIMER_HI_ADDR, 4'b0000, 32'd0, rd_val);
    check_equal("timer_hi", 32'd0, rd_val);

    // Unmapped space
    bus_access(32'h6000_0100, 4'b0000, 32'd0, rd_val);
    check_equal("unmapped rdata", 32'd0, rd_val);
    bus_access(32'h3000_0008, 4'b0000, 32'd0, rd_val);
    bus_access(32'h5000_0008, 4'b1111, 32'hDEAD_BEEF, rd_val);
    bus_access(32'h4000_0008, 4'b0000, 32'd0, rd_val);

    // UART program load of three words
    uart_send(8'h3C);
    check_equal("prog_mode_o", 32'd0, 32'(prog_mode_o));
    uart_send(soc_mem_pkg::PROG_CMD_LOAD);
    check_equal("prog_mode_o", 32'd1, 32'(prog_mode_o));
    check_equal("cpu_rst_n_o", 32'd0, 32'(cpu_rst_n_o));
    uart_send(8'd3);
    uart_send(8'd0);
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      image[i] = rnd[7:0];
      uart_send(image[i]);
      if (i < 11) begin
        check_equal("prog_mode_o", 32'd1, 32'(prog_mode_o));
        check_equal("cpu_rst_n_o", 32'd0, 32'(cpu_rst_n_o));
      end
    end
    waited = 0;
    while (prog_mode_o) begin
      if (waited > 1000) abort_run("Loader never left programming mode");
      waited++;
      @(posedge clk_i);
      #1;
    end
    check_equal("cpu_rst_n_o", 32'd1, 32'(cpu_rst_n_o));
    for (int w = 0; w < 3; w++) begin
      shadow[w] = {image[4*w+3], image[4*w+2], image[4*w+1], image[4*w]};
    end
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, 4'b0000, 32'd0, rd_val);
    assert (rd_val < 32'd64) else abort_run($sformatf("Timer did not restart, read %0d", rd_val));
    for (int w = 0; w < 3; w++) begin
      bus_access(soc_mem_pkg::RAM_BASE_ADDR + 32'(w * 4), 4'b0000, 32'd0, rd_val);
    end

    // Random mix over all regions
    for (int n = 0; n < 200; n++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      pick  = $random(seed);
      case (rnd[1:0])
        2'd0, 2'd1: addr = soc_mem_pkg::RAM_BASE_ADDR | (rnd & 32'h000F_F07C);
        2'd2:       addr = rnd[2] ? soc_mem_pkg::TIMER_HI_ADDR : soc_mem_pkg::TIMER_LO_ADDR;
        default:    addr = 32'h6000_0000 | (rnd & 32'h0FFF_FFFC);
      endcase
      bus_access(addr, pick[0] ? 4'b0000 : pick[4:1], wdata, rd_val);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
